// ==== logic/isaPkg.sv ====
// ISA types for the 16-bit core
// Opcodes, register indices, instruction formats and the instruction union
`default_nettype none

package isaPkg;

    typedef logic [15:0] wordT;
    typedef logic [2:0]  regIdxT;

    localparam int numRegs = 8;
    // Jump-and-link writes the return address here
    localparam regIdxT linkReg = 3'd7;

    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJal   = 5'b00110,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opSlbi  = 5'b10010,
        opLbi   = 5'b11000,
        opAlur  = 5'b11011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd    = 3'd0,
        aluSub    = 3'd1,
        aluXor    = 3'd2,
        aluAndn   = 3'd3,
        aluPassB  = 3'd4,
        aluShl8Or = 3'd5
    } aluOpT;

    // Destination register source
    typedef enum logic [1:0] {
        dstIRd   = 2'd0,
        dstRRd   = 2'd1,
        dstRs    = 2'd2,
        dstLink  = 2'd3
    } dstSelT;

    typedef enum logic [2:0] {
        immSign5  = 3'd0,
        immZero5  = 3'd1,
        immSign8  = 3'd2,
        immZero8  = 3'd3,
        immSign11 = 3'd4
    } immKindT;

    typedef struct packed {
        opcodeT      opcode;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        logic [1:0]  func;
    } rFmtT;

    // I-format 1 carries rd and a 5-bit immediate
    typedef struct packed {
        opcodeT      opcode;
        regIdxT      rs;
        regIdxT      rd;
        logic [4:0]  imm5;
    } iFmt1T;

    // I-format 2 reuses the rd bits as the top of imm8
    typedef struct packed {
        opcodeT      opcode;
        regIdxT      rs;
        logic [7:0]  imm8;
    } iFmt2T;

    typedef union packed {
        iFmt1T f1;
        iFmt2T f2;
    } iFmtU;

    typedef struct packed {
        opcodeT      opcode;
        logic [10:0] disp11;
    } jFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtU iFmt;
        jFmtT jFmt;
    } instrU;

endpackage

`default_nettype wire

// ==== logic/pipePkg.sv ====
// Pipeline payload types
// Control bundle, writeback update and ID/EX register contents
`default_nettype none

package pipePkg;

    // Control bundle carried from decode into execute
    typedef struct packed {
        isaPkg::aluOpT aluOp;
        logic          aluSrcImm;
        logic          memRead;
        logic          memWrite;
        logic          memToReg;
        logic          regWrite;
        logic          branch;
        logic          jump;
        logic          halt;
    } ctrlT;

    // One register update from the writeback stage
    typedef struct packed {
        logic           regWrite;
        isaPkg::regIdxT wrReg;
        isaPkg::wordT   data;
    } wbT;

    typedef struct packed {
        // Address of the next instruction
        isaPkg::wordT   pc2;
        isaPkg::wordT   rd1;
        isaPkg::wordT   rd2;
        isaPkg::wordT   imm;
        // rt index kept for forwarding in later stages
        isaPkg::regIdxT rd2Addr;
        isaPkg::regIdxT wrReg;
        ctrlT           ctrl;
        logic           illegal;
    } idExT;

endpackage

`default_nettype wire

// ==== logic/ctrlDecoder.sv ====
// Opcode decoder
// Builds the control bundle, destination select, immediate kind and illegal flag
`timescale 1ns/1ps
`default_nettype none

module ctrlDecoder (
    input  isaPkg::instrU   instr,
    output pipePkg::ctrlT   ctrl,
    output isaPkg::dstSelT  dstSel,
    output isaPkg::immKindT immKind,
    output logic            illegal
);
    import isaPkg::*;

    always_comb begin
        // Safe defaults behave like a NOP
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        dstSel     = dstIRd;
        immKind    = immSign5;
        illegal    = 1'b0;

        case (instr.rFmt.opcode)
            opAddi, opSubi, opXori, opAndni: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                case (instr.rFmt.opcode)
                    opSubi:  ctrl.aluOp = aluSub;
                    opXori:  ctrl.aluOp = aluXor;
                    opAndni: ctrl.aluOp = aluAndn;
                    default: ctrl.aluOp = aluAdd;
                endcase
                // Logical immediates are zero extended
                if (instr.rFmt.opcode == opXori || instr.rFmt.opcode == opAndni) begin
                    immKind = immZero5;
                end
            end
            opLd: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.regWrite  = 1'b1;
            end
            opSt: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
            end
            opLbi: begin
                ctrl.aluOp     = aluPassB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                dstSel         = dstRs;
                immKind        = immSign8;
            end
            opSlbi: begin
                ctrl.aluOp     = aluShl8Or;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                dstSel         = dstRs;
                immKind        = immZero8;
            end
            opBeqz: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.branch    = 1'b1;
                immKind        = immSign8;
            end
            opAlur: begin
                ctrl.regWrite = 1'b1;
                dstSel        = dstRRd;
                // Function field picks the ALU operation
                case (instr.rFmt.func)
                    2'b00:   ctrl.aluOp = aluAdd;
                    2'b01:   ctrl.aluOp = aluSub;
                    2'b10:   ctrl.aluOp = aluXor;
                    default: ctrl.aluOp = aluAndn;
                endcase
            end
            opJ: begin
                ctrl.jump = 1'b1;
                immKind   = immSign11;
            end
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                dstSel        = dstLink;
                immKind       = immSign11;
            end
            opHalt:  ctrl.halt = 1'b1;
            opNop:   ctrl.aluOp = aluAdd;
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
// Eight-entry register file
// Two read ports, one write port, writeback bypass on both reads
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT rdAddr1,
    input  isaPkg::regIdxT rdAddr2,
    input  pipePkg::wbT    wb,
    output isaPkg::wordT   rdData1,
    output isaPkg::wordT   rdData2
);
    import isaPkg::*;

    wordT regs [numRegs];
    logic hit1;
    logic hit2;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite) begin
            regs[wb.wrReg] <= wb.data;
        end
    end

    // Same-cycle write wins over the stored value
    assign hit1 = wb.regWrite && (wb.wrReg == rdAddr1);
    assign hit2 = wb.regWrite && (wb.wrReg == rdAddr2);

    assign rdData1 = hit1 ? wb.data : regs[rdAddr1];
    assign rdData2 = hit2 ? wb.data : regs[rdAddr2];

endmodule

`default_nettype wire

// ==== logic/operandFormer.sv ====
// Immediate extension and destination register selection
`timescale 1ns/1ps
`default_nettype none

module operandFormer (
    input  isaPkg::wordT    instr,
    input  isaPkg::dstSelT  dstSel,
    input  isaPkg::immKindT immKind,
    output isaPkg::wordT    imm,
    output isaPkg::regIdxT  wrReg
);
    import isaPkg::*;

    always_comb begin
        case (immKind)
            immSign5:  imm = {{11{instr[4]}}, instr[4:0]};
            immZero5:  imm = {11'b0, instr[4:0]};
            immSign8:  imm = {{8{instr[7]}}, instr[7:0]};
            immZero8:  imm = {8'h00, instr[7:0]};
            immSign11: imm = {{5{instr[10]}}, instr[10:0]};
            default:   imm = '0;
        endcase
    end

    // I-format 1 rd, R-format rd, I-format 2 rs or the link register
    always_comb begin
        case (dstSel)
            dstIRd:  wrReg = instr[7:5];
            dstRRd:  wrReg = instr[4:2];
            dstRs:   wrReg = instr[10:8];
            default: wrReg = linkReg;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/idExReg.sv ====
// ID/EX pipeline register with valid/ready handshake and flush
`timescale 1ns/1ps
`default_nettype none

module idExReg (
    input  logic          clk,
    input  logic          rstN,
    input  logic          flush,
    input  logic          inValid,
    output logic          inReady,
    input  pipePkg::idExT in,
    output logic          outValid,
    input  logic          outReady,
    output pipePkg::idExT out
);

    logic take;

    // Stage is free when empty or when execute drains it this cycle
    assign inReady = !outValid || outReady;
    assign take    = inValid && inReady && !flush;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (flush) begin
            // Squash both the held and the offered instruction
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // Payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (take) begin
            out <= in;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decodeTop.sv ====
// Decode stage top level
// Decoder, operand former, register file and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decodeTop (
    input  logic          clk,
    input  logic          rstN,
    input  logic          flush,
    input  logic          inValid,
    output logic          inReady,
    input  isaPkg::wordT  instr,
    input  isaPkg::wordT  pc2,
    input  pipePkg::wbT   wb,
    output logic          outValid,
    input  logic          outReady,
    output pipePkg::idExT out
);
    import isaPkg::*;
    import pipePkg::*;

    instrU   instrView;
    ctrlT    ctrl;
    dstSelT  dstSel;
    immKindT immKind;
    logic    illegal;
    wordT    imm;
    wordT    rd1;
    wordT    rd2;
    regIdxT  wrReg;
    idExT    stageIn;

    assign instrView = instr;

    ctrlDecoder u_ctrlDecoder (
        .instr   (instrView),
        .ctrl    (ctrl),
        .dstSel  (dstSel),
        .immKind (immKind),
        .illegal (illegal)
    );

    operandFormer u_operandFormer (
        .instr   (instr),
        .dstSel  (dstSel),
        .immKind (immKind),
        .imm     (imm),
        .wrReg   (wrReg)
    );

    // rs from bits 10 to 8 and rt from bits 7 to 5
    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddr1 (instrView.rFmt.rs),
        .rdAddr2 (instrView.rFmt.rt),
        .wb      (wb),
        .rdData1 (rd1),
        .rdData2 (rd2)
    );

    always_comb begin
        stageIn.pc2     = pc2;
        stageIn.rd1     = rd1;
        stageIn.rd2     = rd2;
        stageIn.imm     = imm;
        stageIn.rd2Addr = instrView.rFmt.rt;
        stageIn.wrReg   = wrReg;
        stageIn.ctrl    = ctrl;
        stageIn.illegal = illegal;
    end

    idExReg u_idExReg (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (flush),
        .inValid  (inValid),
        .inReady  (inReady),
        .in       (stageIn),
        .outValid (outValid),
        .outReady (outReady),
        .out      (out)
    );

endmodule

`default_nettype wire

// ==== verif/tbChecks.svh ====
// Typed compare tasks, LCG and handshake wait helpers
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic checkCtrl(input string name, input ctrlT exp, input ctrlT act);
    if (exp !== act) begin
        stopWithFailure($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
    end
endtask

task automatic checkWord(input string name, input wordT exp, input wordT act);
    if (exp !== act) begin
        stopWithFailure($sformatf("FAIL %0t %s expected %h got %h", $time, name, exp, act));
    end
endtask

task automatic checkIdx(input string name, input regIdxT exp, input regIdxT act);
    if (exp !== act) begin
        stopWithFailure($sformatf("FAIL %0t %s expected %0d got %0d", $time, name, exp, act));
    end
endtask

// Linear congruential generator returning its upper bits
function automatic int unsigned nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
endfunction

// Returns on the falling edge before a transfer into decode
task automatic waitInReady();
    int count;
    count = 0;
    @(negedge clk);
    while (!inReady) begin
        count++;
        if (count >= 50) begin
            stopWithFailure("Decode never raised inReady within 50 cycles");
        end
        @(negedge clk);
    end
endtask

// Waits until every expected payload has left the stage
task automatic waitDrained();
    int count;
    count = 0;
    @(negedge clk);
    while (expQ.size() != 0 || outValid) begin
        count++;
        if (count >= 50) begin
            stopWithFailure("Decode never delivered outValid for all accepted instructions");
        end
        @(negedge clk);
    end
    @(posedge clk);
    #1;
endtask

`endif

// ==== verif/tbDecodeTop.sv ====
// Testbench for the decode stage
// Stimulus table, back-pressure and flush sequences with a scoreboard
`timescale 1ns/1ps
`default_nettype none

module tbDecodeTop;
    import isaPkg::*;
    import pipePkg::*;

    localparam int numRows = 22;

    logic        clk;
    logic        rstN;
    logic        flush;
    logic        inValid;
    logic        inReady;
    wordT        instr;
    wordT        pc2;
    wbT          wb;
    logic        outValid;
    logic        outReady;
    idExT        out;

    int unsigned seed;
    logic        randomReady;
    logic        holdPending;
    idExT        heldOut;
    idExT        expQ[$];

    wbT          tblWb    [numRows];
    wordT        tblInstr [numRows];
    idExT        tblExp   [numRows];

    decodeTop u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (flush),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .pc2      (pc2),
        .wb       (wb),
        .outValid (outValid),
        .outReady (outReady),
        .out      (out)
    );

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    `include "tbChecks.svh"

    function automatic ctrlT mkCtrl(input aluOpT op, input logic [7:0] f);
        ctrlT c;
        c.aluOp = op;
        {c.aluSrcImm, c.memRead, c.memWrite, c.memToReg,
         c.regWrite, c.branch, c.jump, c.halt} = f;
        return c;
    endfunction

    task automatic setRow(input int i, input wbT w, input wordT ins, input ctrlT c,
                          input wordT r1, input wordT r2, input wordT im,
                          input regIdxT a2, input regIdxT wr, input logic ill);
        tblWb[i]            = w;
        tblInstr[i]         = ins;
        tblExp[i].pc2       = 16'h0100 + 16'(i * 2);
        tblExp[i].rd1       = r1;
        tblExp[i].rd2       = r2;
        tblExp[i].imm       = im;
        tblExp[i].rd2Addr   = a2;
        tblExp[i].wrReg     = wr;
        tblExp[i].ctrl      = c;
        tblExp[i].illegal   = ill;
    endtask

    // Flag bits in order src memRd memWr memToReg regWr branch jump halt
    task automatic loadTable();
        wbT none;
        none = '0;
        setRow(0, none, 16'hD94C, mkCtrl(aluAdd, 8'b0000_1000), 0, 0, 16'h000C, 2, 3, 0);
        // Rows 1 and 2 write r1 and r2 in the decode cycle itself
        setRow(1, '{1'b1, 3'd1, 16'h1234}, 16'hD94D, mkCtrl(aluSub, 8'b0000_1000),
               16'h1234, 0, 16'h000D, 2, 3, 0);
        setRow(2, '{1'b1, 3'd2, 16'hABCD}, 16'hD94E, mkCtrl(aluXor, 8'b0000_1000),
               16'h1234, 16'hABCD, 16'h000E, 2, 3, 0);
        setRow(3, none, 16'hDA37, mkCtrl(aluAndn, 8'b0000_1000),
               16'hABCD, 16'h1234, 16'hFFF7, 1, 5, 0);
        setRow(4, none, 16'h4191, mkCtrl(aluAdd, 8'b1000_1000), 16'h1234, 0, 16'hFFF1, 4, 4, 0);
        setRow(5, none, 16'h418F, mkCtrl(aluAdd, 8'b1000_1000), 16'h1234, 0, 16'h000F, 4, 4, 0);
        setRow(6, none, 16'h4823, mkCtrl(aluSub, 8'b1000_1000), 0, 16'h1234, 16'h0003, 1, 1, 0);
        setRow(7, none, 16'h5055, mkCtrl(aluXor, 8'b1000_1000), 0, 16'hABCD, 16'h0015, 2, 2, 0);
        setRow(8, none, 16'h580F, mkCtrl(aluAndn, 8'b1000_1000), 0, 0, 16'h000F, 0, 0, 0);
        setRow(9, none, 16'h8941, mkCtrl(aluAdd, 8'b1101_1000),
               16'h1234, 16'hABCD, 16'h0001, 2, 2, 0);
        setRow(10, none, 16'h823E, mkCtrl(aluAdd, 8'b1010_0000),
               16'hABCD, 16'h1234, 16'hFFFE, 1, 1, 0);
        setRow(11, none, 16'hC385, mkCtrl(aluPassB, 8'b1000_1000), 0, 0, 16'hFF85, 4, 3, 0);
        setRow(12, none, 16'hC37F, mkCtrl(aluPassB, 8'b1000_1000), 0, 0, 16'h007F, 3, 3, 0);
        setRow(13, none, 16'h919A, mkCtrl(aluShl8Or, 8'b1000_1000),
               16'h1234, 0, 16'h009A, 4, 1, 0);
        setRow(14, none, 16'h911A, mkCtrl(aluShl8Or, 8'b1000_1000),
               16'h1234, 0, 16'h001A, 0, 1, 0);
        setRow(15, none, 16'h62F0, mkCtrl(aluAdd, 8'b1000_0100), 16'hABCD, 0, 16'hFFF0, 7, 7, 0);
        setRow(16, none, 16'h6210, mkCtrl(aluAdd, 8'b1000_0100), 16'hABCD, 0, 16'h0010, 0, 0, 0);
        setRow(17, none, 16'h2400, mkCtrl(aluAdd, 8'b0000_0010), 0, 0, 16'hFC00, 0, 0, 0);
        setRow(18, none, 16'h3300, mkCtrl(aluAdd, 8'b0000_1010), 0, 0, 16'h0300, 0, 7, 0);
        setRow(19, none, 16'h0000, mkCtrl(aluAdd, 8'b0000_0001), 0, 0, 16'h0000, 0, 0, 0);
        setRow(20, none, 16'h0800, mkCtrl(aluAdd, 8'b0000_0000), 0, 0, 16'h0000, 0, 0, 0);
        // Unlisted opcode 11111
        setRow(21, none, 16'hF8FF, mkCtrl(aluAdd, 8'b0000_0000), 0, 0, 16'hFFFF, 7, 7, 1);
    endtask

    task automatic comparePayload(input string name, input idExT exp, input idExT act);
        checkWord({name, ".pc2"}, exp.pc2, act.pc2);
        checkWord({name, ".rd1"}, exp.rd1, act.rd1);
        checkWord({name, ".rd2"}, exp.rd2, act.rd2);
        checkWord({name, ".imm"}, exp.imm, act.imm);
        checkIdx({name, ".rd2Addr"}, exp.rd2Addr, act.rd2Addr);
        checkIdx({name, ".wrReg"}, exp.wrReg, act.wrReg);
        checkCtrl({name, ".ctrl"}, exp.ctrl, act.ctrl);
        checkWord({name, ".illegal"}, {15'b0, exp.illegal}, {15'b0, act.illegal});
    endtask

    // Offers one table row; the expected payload is queued when the transfer is due
    task automatic sendInstr(input int i, input logic useWb);
        inValid = 1'b1;
        instr   = tblInstr[i];
        pc2     = tblExp[i].pc2;
        wb      = useWb ? tblWb[i] : '0;
        waitInReady();
        expQ.push_back(tblExp[i]);
        @(posedge clk);
        #1;
        inValid = 1'b0;
        wb      = '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always begin
        @(posedge clk);
        #1;
        if (randomReady) begin
            outReady = (nextRand() % 4) != 0;
        end
    end

    // Output monitor samples on the falling edge where everything is settled
    always @(negedge clk) begin
        if (rstN && outValid) begin
            if (holdPending) begin
                comparePayload("held out", heldOut, out);
            end
            if (!outReady) begin
                if (inReady) begin
                    stopWithFailure("inReady stayed high while the output was stalled");
                end
                holdPending = 1'b1;
                heldOut     = out;
            end else begin
                holdPending = 1'b0;
                if (expQ.size() == 0) begin
                    stopWithFailure("Decode delivered an instruction that was never accepted");
                end
                comparePayload("out", expQ.pop_front(), out);
            end
        end else begin
            holdPending = 1'b0;
        end
    end

    initial begin
        rstN        = 1'b0;
        flush       = 1'b0;
        inValid     = 1'b0;
        instr       = '0;
        pc2         = '0;
        wb          = '0;
        outReady    = 1'b0;
        randomReady = 1'b0;
        seed        = 65323;
        holdPending = 1'b0;
        loadTable();

        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        if (outValid) begin
            stopWithFailure("outValid was high after reset");
        end
        @(posedge clk);
        #1;
        outReady = 1'b1;

        for (int i = 0; i < numRows; i++) begin
            sendInstr(i, 1'b1);
        end
        waitDrained();

        // Random back-pressure on the rows that need no writeback
        randomReady = 1'b1;
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 3; i < numRows; i++) begin
                sendInstr(i, 1'b0);
            end
        end
        waitDrained();
        randomReady = 1'b0;
        @(posedge clk);
        #1;
        outReady = 1'b1;

        // Row 5 is offered together with the flush and must vanish
        sendInstr(4, 1'b0);
        inValid = 1'b1;
        instr   = tblInstr[5];
        pc2     = tblExp[5].pc2;
        flush   = 1'b1;
        @(posedge clk);
        #1;
        flush   = 1'b0;
        inValid = 1'b0;
        @(negedge clk);
        if (outValid) begin
            stopWithFailure("outValid was still high after the flush");
        end
        @(posedge clk);
        #1;
        sendInstr(6, 1'b0);
        sendInstr(7, 1'b0);
        waitDrained();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== decodeStage.f ====
+incdir+verif
logic/isaPkg.sv
logic/pipePkg.sv
logic/ctrlDecoder.sv
logic/regFile.sv
logic/operandFormer.sv
logic/idExReg.sv
logic/decodeTop.sv
verif/tbDecodeTop.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbDecodeTop -f decodeStage.f -o simDecode
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simDecode
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation passed"
exit 0
